// File: include/axi_mem_defines.svh
`ifndef AXI_MEM_DEFINES_SVH
`define AXI_MEM_DEFINES_SVH

// --------------------
// AXI port widths
// --------------------
`define AXI_ADDR_WIDTH 10
`define AXI_DATA_WIDTH 32
`define AXI_STRB_WIDTH 4
`define AXI_ID_WIDTH   4

// --------------------
// RAM geometry
// --------------------
// 256 words of 32 bits
`define MEM_ADDR_WIDTH 8
// Byte offset bits within a word
`define MEM_LSB        2

`endif

// File: source/axi_mem_pkg.sv
package axi_mem_pkg;

  // AXI burst kinds, encoded as on the bus
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_t;

  // Response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_t;

  // Write engine FSM
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_BEAT,
    WR_WAIT_ACK,
    WR_RESP
  } wr_state_t;

  // Read engine FSM
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_REQ,
    RD_WAIT_ACK,
    RD_OUT
  } rd_state_t;

endpackage

// File: source/mem_port_pkg.sv
package mem_port_pkg;

  // Operation on the single RAM port
  typedef enum logic {
    MEM_OP_READ  = 1'b0,
    MEM_OP_WRITE = 1'b1
  } mem_op_t;

  // Arbiter FSM
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_ACCESS,
    ARB_ACK
  } arb_state_t;

endpackage

// File: source/byte_lane_ram.sv
`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module byte_lane_ram (
  input  logic                       clk,
  input  logic                       i_mem_en,
  input  mem_port_pkg::mem_op_t      i_mem_op,
  input  logic [`MEM_ADDR_WIDTH-1:0] i_mem_addr,
  input  logic [`AXI_DATA_WIDTH-1:0] i_mem_wdata,
  input  logic [`AXI_STRB_WIDTH-1:0] i_mem_be,
  output logic [`AXI_DATA_WIDTH-1:0] o_mem_rdata
);
  import mem_port_pkg::*;

  logic [`AXI_DATA_WIDTH-1:0] mem [0:(1 << `MEM_ADDR_WIDTH)-1];

  // Write per byte lane, read data registered
  always_ff @(posedge clk) begin
    if (i_mem_en) begin
      if (i_mem_op == MEM_OP_WRITE) begin
        for (int i = 0; i < `AXI_STRB_WIDTH; i++) begin
          if (i_mem_be[i]) mem[i_mem_addr][8*i +: 8] <= i_mem_wdata[8*i +: 8];
        end
      end else begin
        o_mem_rdata <= mem[i_mem_addr];
      end
    end
  end

endmodule

// File: source/mem_port_arbiter.sv
`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module mem_port_arbiter (
  input  logic                       clk,
  input  logic                       rst_n,
  // Write engine port
  input  logic                       i_wr_req,
  input  logic [`AXI_ADDR_WIDTH-1:0] i_wr_addr,
  input  logic [`AXI_DATA_WIDTH-1:0] i_wr_data,
  input  logic [`AXI_STRB_WIDTH-1:0] i_wr_be,
  output logic                       o_wr_ack,
  // Read engine port
  input  logic                       i_rd_req,
  input  logic [`AXI_ADDR_WIDTH-1:0] i_rd_addr,
  output logic                       o_rd_ack,
  output logic [`AXI_DATA_WIDTH-1:0] o_rd_data,
  // RAM port
  output logic                       o_mem_en,
  output mem_port_pkg::mem_op_t      o_mem_op,
  output logic [`MEM_ADDR_WIDTH-1:0] o_mem_addr,
  output logic [`AXI_DATA_WIDTH-1:0] o_mem_wdata,
  output logic [`AXI_STRB_WIDTH-1:0] o_mem_be,
  input  logic [`AXI_DATA_WIDTH-1:0] i_mem_rdata
);
  import mem_port_pkg::*;

  arb_state_t state;
  logic       last_wr;
  logic       pick_wr;
  logic       grant_wr;
  logic       granted_req;

  // Round robin: on a tie, the side not served last wins
  assign pick_wr     = i_wr_req && (!i_rd_req || !last_wr);
  assign grant_wr    = (o_mem_op == MEM_OP_WRITE);
  assign granted_req = grant_wr ? i_wr_req : i_rd_req;
  assign o_mem_en    = (state == ARB_ACCESS);

  // --------------------
  // FSM and acks
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= ARB_IDLE;
      last_wr  <= 1'b0;
      o_wr_ack <= 1'b0;
      o_rd_ack <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (i_wr_req || i_rd_req) begin
            last_wr <= pick_wr;
            state   <= ARB_ACCESS;
          end
        end
        ARB_ACCESS: state <= ARB_ACK;
        ARB_ACK: begin
          // First cycle raises ack, then wait for req to drop
          if (!o_wr_ack && !o_rd_ack) begin
            o_wr_ack <= grant_wr;
            o_rd_ack <= !grant_wr;
          end else if (!granted_req) begin
            o_wr_ack <= 1'b0;
            o_rd_ack <= 1'b0;
            state    <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  // --------------------
  // RAM command and read data
  // --------------------
  always_ff @(posedge clk) begin
    if (state == ARB_IDLE && (i_wr_req || i_rd_req)) begin
      o_mem_op    <= pick_wr ? MEM_OP_WRITE : MEM_OP_READ;
      o_mem_addr  <= pick_wr ? i_wr_addr[`AXI_ADDR_WIDTH-1:`MEM_LSB]
                             : i_rd_addr[`AXI_ADDR_WIDTH-1:`MEM_LSB];
      o_mem_wdata <= i_wr_data;
      o_mem_be    <= pick_wr ? i_wr_be : '0;
    end
    if (state == ARB_ACK && !o_rd_ack && !grant_wr) o_rd_data <= i_mem_rdata;
  end

  a_one_ack: assert property (@(posedge clk) disable iff (!rst_n)
    !(o_wr_ack && o_rd_ack))
    else $error("write and read ack high together");

  a_en_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    o_mem_en |=> !o_mem_en)
    else $error("RAM enable held past one cycle");

endmodule

// File: source/axi_write_engine.sv
`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module axi_write_engine (
  input  logic                       clk,
  input  logic                       rst_n,
  // AW channel
  input  logic                       i_axi_awvalid,
  input  logic [`AXI_ID_WIDTH-1:0]   i_axi_awid,
  input  logic [`AXI_ADDR_WIDTH-1:0] i_axi_awaddr,
  input  logic [7:0]                 i_axi_awlen,
  input  logic [2:0]                 i_axi_awsize,
  input  axi_mem_pkg::burst_t        i_axi_awburst,
  output logic                       o_axi_awready,
  // W channel
  input  logic                       i_axi_wvalid,
  input  logic [`AXI_DATA_WIDTH-1:0] i_axi_wdata,
  input  logic [`AXI_STRB_WIDTH-1:0] i_axi_wstrb,
  input  logic                       i_axi_wlast,
  output logic                       o_axi_wready,
  // B channel
  output logic                       o_axi_bvalid,
  output logic [`AXI_ID_WIDTH-1:0]   o_axi_bid,
  output axi_mem_pkg::resp_t         o_axi_bresp,
  input  logic                       i_axi_bready,
  // Request port to the arbiter
  output logic                       o_wr_req,
  output logic [`AXI_ADDR_WIDTH-1:0] o_wr_addr,
  output logic [`AXI_DATA_WIDTH-1:0] o_wr_data,
  output logic [`AXI_STRB_WIDTH-1:0] o_wr_be,
  input  logic                       i_wr_ack
);
  import axi_mem_pkg::*;

  wr_state_t                  state;
  logic [`AXI_ID_WIDTH-1:0]   id_q;
  logic [`AXI_ADDR_WIDTH-1:0] addr_q;
  logic [`AXI_ADDR_WIDTH-1:0] addr_step;
  logic [2:0]                 size_q;
  burst_t                     burst_q;
  logic [7:0]                 beat_cnt;
  logic                       aw_hs;
  logic                       w_hs;
  logic                       beat_done;

  // Wait for the previous ack to fall before taking the next beat
  assign o_axi_awready = (state == WR_IDLE);
  assign o_axi_wready  = (state == WR_BEAT) && !i_wr_ack;
  assign o_axi_bvalid  = (state == WR_RESP);
  assign o_axi_bid     = id_q;
  assign o_axi_bresp   = RESP_OKAY;
  assign o_wr_addr     = addr_q;

  assign aw_hs     = i_axi_awvalid && o_axi_awready;
  assign w_hs      = i_axi_wvalid && o_axi_wready;
  assign beat_done = (state == WR_WAIT_ACK) && i_wr_ack;
  assign addr_step = `AXI_ADDR_WIDTH'(1) << size_q;

  // --------------------
  // FSM
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= WR_IDLE;
      o_wr_req <= 1'b0;
    end else begin
      case (state)
        WR_IDLE: begin
          if (aw_hs) state <= WR_BEAT;
        end
        WR_BEAT: begin
          if (w_hs) begin
            o_wr_req <= 1'b1;
            state    <= WR_WAIT_ACK;
          end
        end
        WR_WAIT_ACK: begin
          if (i_wr_ack) begin
            o_wr_req <= 1'b0;
            state    <= (beat_cnt == 8'd0) ? WR_RESP : WR_BEAT;
          end
        end
        WR_RESP: begin
          if (i_axi_bready) state <= WR_IDLE;
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  // --------------------
  // Burst context and beat payload
  // --------------------
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      id_q     <= i_axi_awid;
      addr_q   <= i_axi_awaddr;
      size_q   <= i_axi_awsize;
      burst_q  <= i_axi_awburst;
      beat_cnt <= i_axi_awlen;
    end
    if (w_hs) begin
      o_wr_data <= i_axi_wdata;
      o_wr_be   <= i_axi_wstrb;
    end
    // Step only after the RAM has taken the beat
    if (beat_done) begin
      beat_cnt <= beat_cnt - 8'd1;
      if (burst_q != BURST_FIXED) addr_q <= addr_q + addr_step;
    end
  end

  // Master must mark the beat the AW length promised
  a_wlast_on_len: assert property (@(posedge clk) disable iff (!rst_n)
    w_hs |-> (i_axi_wlast == (beat_cnt == 8'd0)))
    else $error("wlast does not match awlen");

  a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
    aw_hs |-> (i_axi_awburst != BURST_WRAP))
    else $error("WRAP burst on AW, handled as INCR");

  a_req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(o_wr_req) |-> !i_wr_ack)
    else $error("write req rose while ack high");

endmodule

// File: source/axi_read_engine.sv
`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module axi_read_engine (
  input  logic                       clk,
  input  logic                       rst_n,
  // AR channel
  input  logic                       i_axi_arvalid,
  input  logic [`AXI_ID_WIDTH-1:0]   i_axi_arid,
  input  logic [`AXI_ADDR_WIDTH-1:0] i_axi_araddr,
  input  logic [7:0]                 i_axi_arlen,
  input  logic [2:0]                 i_axi_arsize,
  input  axi_mem_pkg::burst_t        i_axi_arburst,
  output logic                       o_axi_arready,
  // R channel
  output logic                       o_axi_rvalid,
  output logic [`AXI_ID_WIDTH-1:0]   o_axi_rid,
  output logic [`AXI_DATA_WIDTH-1:0] o_axi_rdata,
  output axi_mem_pkg::resp_t         o_axi_rresp,
  output logic                       o_axi_rlast,
  input  logic                       i_axi_rready,
  // Request port to the arbiter
  output logic                       o_rd_req,
  output logic [`AXI_ADDR_WIDTH-1:0] o_rd_addr,
  input  logic                       i_rd_ack,
  input  logic [`AXI_DATA_WIDTH-1:0] i_rd_data
);
  import axi_mem_pkg::*;

  rd_state_t                  state;
  logic [`AXI_ID_WIDTH-1:0]   id_q;
  logic [`AXI_ADDR_WIDTH-1:0] addr_q;
  logic [`AXI_ADDR_WIDTH-1:0] addr_step;
  logic [2:0]                 size_q;
  burst_t                     burst_q;
  logic [7:0]                 beat_cnt;
  logic                       ar_hs;
  logic                       r_hs;

  assign o_axi_arready = (state == RD_IDLE);
  assign o_axi_rvalid  = (state == RD_OUT);
  assign o_axi_rid     = id_q;
  assign o_axi_rresp   = RESP_OKAY;
  // Count reaches zero on the final beat
  assign o_axi_rlast   = (beat_cnt == 8'd0);
  assign o_rd_addr     = addr_q;

  assign ar_hs     = i_axi_arvalid && o_axi_arready;
  assign r_hs      = o_axi_rvalid && i_axi_rready;
  assign addr_step = `AXI_ADDR_WIDTH'(1) << size_q;

  // --------------------
  // FSM
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= RD_IDLE;
      o_rd_req <= 1'b0;
    end else begin
      case (state)
        RD_IDLE: begin
          if (ar_hs) state <= RD_REQ;
        end
        // Hold off until the previous ack has fallen
        RD_REQ: begin
          if (!i_rd_ack) begin
            o_rd_req <= 1'b1;
            state    <= RD_WAIT_ACK;
          end
        end
        RD_WAIT_ACK: begin
          if (i_rd_ack) begin
            o_rd_req <= 1'b0;
            state    <= RD_OUT;
          end
        end
        RD_OUT: begin
          if (i_axi_rready) state <= o_axi_rlast ? RD_IDLE : RD_REQ;
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  // --------------------
  // Burst context and read data
  // --------------------
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      id_q     <= i_axi_arid;
      addr_q   <= i_axi_araddr;
      size_q   <= i_axi_arsize;
      burst_q  <= i_axi_arburst;
      beat_cnt <= i_axi_arlen;
    end
    if (state == RD_WAIT_ACK && i_rd_ack) o_axi_rdata <= i_rd_data;
    if (r_hs && !o_axi_rlast) begin
      beat_cnt <= beat_cnt - 8'd1;
      if (burst_q != BURST_FIXED) addr_q <= addr_q + addr_step;
    end
  end

  // Beat stays put under back-pressure
  a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (o_axi_rvalid && !i_axi_rready) |=> (o_axi_rvalid && $stable(o_axi_rdata)))
    else $error("R beat dropped or changed before rready");

  a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
    ar_hs |-> (i_axi_arburst != BURST_WRAP))
    else $error("WRAP burst on AR, handled as INCR");

endmodule

// File: source/axi_mem_top.sv
`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module axi_mem_top (
  input  logic                       clk,
  input  logic                       rst_n,
  // Write address
  input  logic                       i_axi_awvalid,
  input  logic [`AXI_ID_WIDTH-1:0]   i_axi_awid,
  input  logic [`AXI_ADDR_WIDTH-1:0] i_axi_awaddr,
  input  logic [7:0]                 i_axi_awlen,
  input  logic [2:0]                 i_axi_awsize,
  input  axi_mem_pkg::burst_t        i_axi_awburst,
  output logic                       o_axi_awready,
  // Write data
  input  logic                       i_axi_wvalid,
  input  logic [`AXI_DATA_WIDTH-1:0] i_axi_wdata,
  input  logic [`AXI_STRB_WIDTH-1:0] i_axi_wstrb,
  input  logic                       i_axi_wlast,
  output logic                       o_axi_wready,
  // Write response
  output logic                       o_axi_bvalid,
  output logic [`AXI_ID_WIDTH-1:0]   o_axi_bid,
  output axi_mem_pkg::resp_t         o_axi_bresp,
  input  logic                       i_axi_bready,
  // Read address
  input  logic                       i_axi_arvalid,
  input  logic [`AXI_ID_WIDTH-1:0]   i_axi_arid,
  input  logic [`AXI_ADDR_WIDTH-1:0] i_axi_araddr,
  input  logic [7:0]                 i_axi_arlen,
  input  logic [2:0]                 i_axi_arsize,
  input  axi_mem_pkg::burst_t        i_axi_arburst,
  output logic                       o_axi_arready,
  // Read data
  output logic                       o_axi_rvalid,
  output logic [`AXI_ID_WIDTH-1:0]   o_axi_rid,
  output logic [`AXI_DATA_WIDTH-1:0] o_axi_rdata,
  output axi_mem_pkg::resp_t         o_axi_rresp,
  output logic                       o_axi_rlast,
  input  logic                       i_axi_rready
);
  import mem_port_pkg::*;

  // Engine to arbiter
  logic                       wr_req;
  logic [`AXI_ADDR_WIDTH-1:0] wr_addr;
  logic [`AXI_DATA_WIDTH-1:0] wr_data;
  logic [`AXI_STRB_WIDTH-1:0] wr_be;
  logic                       wr_ack;
  logic                       rd_req;
  logic [`AXI_ADDR_WIDTH-1:0] rd_addr;
  logic                       rd_ack;
  logic [`AXI_DATA_WIDTH-1:0] rd_data;

  // Arbiter to RAM
  logic                       mem_en;
  mem_op_t                    mem_op;
  logic [`MEM_ADDR_WIDTH-1:0] mem_addr;
  logic [`AXI_DATA_WIDTH-1:0] mem_wdata;
  logic [`AXI_STRB_WIDTH-1:0] mem_be;
  logic [`AXI_DATA_WIDTH-1:0] mem_rdata;

  axi_write_engine u_wr (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_axi_awvalid (i_axi_awvalid),
    .i_axi_awid    (i_axi_awid),
    .i_axi_awaddr  (i_axi_awaddr),
    .i_axi_awlen   (i_axi_awlen),
    .i_axi_awsize  (i_axi_awsize),
    .i_axi_awburst (i_axi_awburst),
    .o_axi_awready (o_axi_awready),
    .i_axi_wvalid  (i_axi_wvalid),
    .i_axi_wdata   (i_axi_wdata),
    .i_axi_wstrb   (i_axi_wstrb),
    .i_axi_wlast   (i_axi_wlast),
    .o_axi_wready  (o_axi_wready),
    .o_axi_bvalid  (o_axi_bvalid),
    .o_axi_bid     (o_axi_bid),
    .o_axi_bresp   (o_axi_bresp),
    .i_axi_bready  (i_axi_bready),
    .o_wr_req      (wr_req),
    .o_wr_addr     (wr_addr),
    .o_wr_data     (wr_data),
    .o_wr_be       (wr_be),
    .i_wr_ack      (wr_ack)
  );

  axi_read_engine u_rd (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_axi_arvalid (i_axi_arvalid),
    .i_axi_arid    (i_axi_arid),
    .i_axi_araddr  (i_axi_araddr),
    .i_axi_arlen   (i_axi_arlen),
    .i_axi_arsize  (i_axi_arsize),
    .i_axi_arburst (i_axi_arburst),
    .o_axi_arready (o_axi_arready),
    .o_axi_rvalid  (o_axi_rvalid),
    .o_axi_rid     (o_axi_rid),
    .o_axi_rdata   (o_axi_rdata),
    .o_axi_rresp   (o_axi_rresp),
    .o_axi_rlast   (o_axi_rlast),
    .i_axi_rready  (i_axi_rready),
    .o_rd_req      (rd_req),
    .o_rd_addr     (rd_addr),
    .i_rd_ack      (rd_ack),
    .i_rd_data     (rd_data)
  );

  mem_port_arbiter u_arb (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_wr_req    (wr_req),
    .i_wr_addr   (wr_addr),
    .i_wr_data   (wr_data),
    .i_wr_be     (wr_be),
    .o_wr_ack    (wr_ack),
    .i_rd_req    (rd_req),
    .i_rd_addr   (rd_addr),
    .o_rd_ack    (rd_ack),
    .o_rd_data   (rd_data),
    .o_mem_en    (mem_en),
    .o_mem_op    (mem_op),
    .o_mem_addr  (mem_addr),
    .o_mem_wdata (mem_wdata),
    .o_mem_be    (mem_be),
    .i_mem_rdata (mem_rdata)
  );

  byte_lane_ram u_ram (
    .clk         (clk),
    .i_mem_en    (mem_en),
    .i_mem_op    (mem_op),
    .i_mem_addr  (mem_addr),
    .i_mem_wdata (mem_wdata),
    .i_mem_be    (mem_be),
    .o_mem_rdata (mem_rdata)
  );

endmodule

// File: tb/tb_axi_mem.sv
`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module tb_axi_mem;
  import axi_mem_pkg::*;

  // Beat budget of all tests with slack for back-pressure and arbitration
  localparam int MAX_BEATS       = 256 + 2*8 + 2*8*16 + 2*8 + 2*4*16 + 128;
  localparam int CYCLES_PER_BEAT = 10;
  localparam int MAX_CYCLES      = 3 * MAX_BEATS * CYCLES_PER_BEAT;

  logic clk = 1'b0;
  logic rst_n;

  logic                       awvalid, awready;
  logic [`AXI_ID_WIDTH-1:0]   awid;
  logic [`AXI_ADDR_WIDTH-1:0] awaddr;
  logic [7:0]                 awlen;
  logic [2:0]                 awsize;
  burst_t                     awburst;
  logic                       wvalid, wlast, wready;
  logic [`AXI_DATA_WIDTH-1:0] wdata;
  logic [`AXI_STRB_WIDTH-1:0] wstrb;
  logic                       bvalid, bready;
  logic [`AXI_ID_WIDTH-1:0]   bid;
  resp_t                      bresp;
  logic                       arvalid, arready;
  logic [`AXI_ID_WIDTH-1:0]   arid;
  logic [`AXI_ADDR_WIDTH-1:0] araddr;
  logic [7:0]                 arlen;
  logic [2:0]                 arsize;
  burst_t                     arburst;
  logic                       rvalid, rlast, rready;
  logic [`AXI_ID_WIDTH-1:0]   rid;
  logic [`AXI_DATA_WIDTH-1:0] rdata;
  resp_t                      rresp;

  // Byte-wide reference model of the whole address space
  logic [7:0] model [0:(1 << `AXI_ADDR_WIDTH)-1];
  int err_cnt    = 0;
  int test_errs  = 0;
  int test_pass  = 0;
  int test_fail  = 0;
  int cycles     = 0;

  axi_mem_top dut0 (
    .clk (clk), .rst_n (rst_n),
    .i_axi_awvalid (awvalid), .i_axi_awid (awid), .i_axi_awaddr (awaddr),
    .i_axi_awlen (awlen), .i_axi_awsize (awsize), .i_axi_awburst (awburst),
    .o_axi_awready (awready),
    .i_axi_wvalid (wvalid), .i_axi_wdata (wdata), .i_axi_wstrb (wstrb),
    .i_axi_wlast (wlast), .o_axi_wready (wready),
    .o_axi_bvalid (bvalid), .o_axi_bid (bid), .o_axi_bresp (bresp), .i_axi_bready (bready),
    .i_axi_arvalid (arvalid), .i_axi_arid (arid), .i_axi_araddr (araddr),
    .i_axi_arlen (arlen), .i_axi_arsize (arsize), .i_axi_arburst (arburst),
    .o_axi_arready (arready),
    .o_axi_rvalid (rvalid), .o_axi_rid (rid), .o_axi_rdata (rdata),
    .o_axi_rresp (rresp), .o_axi_rlast (rlast), .i_axi_rready (rready)
  );

  always #10 clk = ~clk;

  // Watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles because a handshake never completed", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  // --------------------
  // Compare tasks
  // --------------------
  task automatic compare_data(input string name, input logic [`AXI_DATA_WIDTH-1:0] exp_v,
                              input logic [`AXI_DATA_WIDTH-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("ERROR t=%0t %s expected=%h actual=%h", $time, name, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic compare_resp(input string name, input logic [`AXI_ID_WIDTH-1:0] exp_id,
                              input logic [`AXI_ID_WIDTH-1:0] act_id,
                              input resp_t exp_resp, input resp_t act_resp);
    if (act_id !== exp_id) begin
      $display("ERROR t=%0t %sid expected=%h actual=%h", $time, name, exp_id, act_id);
      err_cnt++;
    end
    if (act_resp !== exp_resp) begin
      $display("ERROR t=%0t %sresp expected=%h actual=%h", $time, name, exp_resp, act_resp);
      err_cnt++;
    end
  endtask

  task automatic compare_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("ERROR t=%0t %s expected=%b actual=%b", $time, name, exp_v, act_v);
      err_cnt++;
    end
  endtask

  // --------------------
  // Model and helpers
  // --------------------
  function automatic logic [`AXI_DATA_WIDTH-1:0] model_word(input logic [`AXI_ADDR_WIDTH-1:0] a);
    logic [`AXI_DATA_WIDTH-1:0] w;
    for (int i = 0; i < `AXI_STRB_WIDTH; i++) begin
      w[8*i +: 8] = model[{a[`AXI_ADDR_WIDTH-1:`MEM_LSB], `MEM_LSB'(i)}];
    end
    return w;
  endfunction

  // Strobed lanes land in the word holding the beat address
  task automatic model_write(input logic [`AXI_ADDR_WIDTH-1:0] a,
                             input logic [`AXI_DATA_WIDTH-1:0] d,
                             input logic [`AXI_STRB_WIDTH-1:0] s);
    for (int i = 0; i < `AXI_STRB_WIDTH; i++) begin
      if (s[i]) model[{a[`AXI_ADDR_WIDTH-1:`MEM_LSB], `MEM_LSB'(i)}] = d[8*i +: 8];
    end
  endtask

  function automatic logic [`AXI_DATA_WIDTH-1:0] fill_word(input logic [7:0] w);
    return {w ^ 8'h3c, ~w, w + 8'h51, w};
  endfunction

  function automatic logic [`AXI_ADDR_WIDTH-1:0] word_addr(input int w);
    return `AXI_ADDR_WIDTH'(w << `MEM_LSB);
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // --------------------
  // Bus transactions
  // --------------------
  task automatic write_burst(input logic [`AXI_ID_WIDTH-1:0] id,
                             input logic [`AXI_ADDR_WIDTH-1:0] addr, input logic [7:0] len,
                             input burst_t burst, input logic use_fill, input logic bp);
    logic [`AXI_ADDR_WIDTH-1:0] a;
    logic [`AXI_DATA_WIDTH-1:0] d;
    logic [`AXI_STRB_WIDTH-1:0] s;
    logic                       done;
    a = addr;
    awvalid = 1'b1;
    awid    = id;
    awaddr  = addr;
    awlen   = len;
    awsize  = 3'd2;
    awburst = burst;
    while (awready !== 1'b1) next_cycle();
    next_cycle();
    awvalid = 1'b0;
    for (int k = 0; k <= int'(len); k++) begin
      if (bp) begin
        while ($urandom_range(3) == 0) next_cycle();
      end
      d = use_fill ? fill_word(a[`AXI_ADDR_WIDTH-1:`MEM_LSB]) : $urandom();
      s = use_fill ? '1 : `AXI_STRB_WIDTH'($urandom());
      wvalid = 1'b1;
      wdata  = d;
      wstrb  = s;
      wlast  = (k == int'(len));
      while (wready !== 1'b1) next_cycle();
      model_write(a, d, s);
      next_cycle();
      wvalid = 1'b0;
      wlast  = 1'b0;
      if (burst != BURST_FIXED) a = a + word_addr(1);
    end
    done = 1'b0;
    while (!done) begin
      bready = bp ? 1'($urandom()) : 1'b1;
      if (bvalid === 1'b1 && bready) begin
        done = 1'b1;
      end else begin
        next_cycle();
      end
    end
    compare_resp("o_axi_b", id, bid, RESP_OKAY, bresp);
    next_cycle();
    bready = 1'b0;
    compare_flag("o_axi_bvalid after B", 1'b0, bvalid);
  endtask

  task automatic read_burst(input logic [`AXI_ID_WIDTH-1:0] id,
                            input logic [`AXI_ADDR_WIDTH-1:0] addr, input logic [7:0] len,
                            input burst_t burst, input logic bp);
    logic [`AXI_ADDR_WIDTH-1:0] a;
    logic                       got;
    a = addr;
    arvalid = 1'b1;
    arid    = id;
    araddr  = addr;
    arlen   = len;
    arsize  = 3'd2;
    arburst = burst;
    while (arready !== 1'b1) next_cycle();
    next_cycle();
    arvalid = 1'b0;
    for (int k = 0; k <= int'(len); k++) begin
      got = 1'b0;
      while (!got) begin
        rready = bp ? 1'($urandom()) : 1'b1;
        if (rvalid === 1'b1 && rready) begin
          got = 1'b1;
        end else begin
          next_cycle();
        end
      end
      compare_data("o_axi_rdata", model_word(a), rdata);
      compare_resp("o_axi_r", id, rid, RESP_OKAY, rresp);
      compare_flag("o_axi_rlast", k == int'(len), rlast);
      next_cycle();
      rready = 1'b0;
      if (burst != BURST_FIXED) a = a + word_addr(1);
    end
    // No extra beat after rlast
    compare_flag("o_axi_rvalid after rlast", 1'b0, rvalid);
  endtask

  task automatic start_test();
    test_errs = err_cnt;
  endtask

  task automatic finish_test(input string name);
    if (err_cnt == test_errs) begin
      test_pass++;
      $display("Test %s: PASS", name);
    end else begin
      test_fail++;
      $display("Test %s: FAIL with %0d errors", name, err_cnt - test_errs);
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    logic [7:0] len;
    int         start;
    void'($urandom(32'h2618));
    rst_n   = 1'b0;
    awvalid = 1'b0;
    awid    = '0;
    awaddr  = '0;
    awlen   = '0;
    awsize  = 3'd2;
    awburst = BURST_INCR;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = 1'b0;
    bready  = 1'b0;
    arvalid = 1'b0;
    arid    = '0;
    araddr  = '0;
    arlen   = '0;
    arsize  = 3'd2;
    arburst = BURST_INCR;
    rready  = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    start_test();
    next_cycle();
    compare_flag("o_axi_awready", 1'b1, awready);
    compare_flag("o_axi_arready", 1'b1, arready);
    compare_flag("o_axi_wready", 1'b0, wready);
    compare_flag("o_axi_bvalid", 1'b0, bvalid);
    compare_flag("o_axi_rvalid", 1'b0, rvalid);
    finish_test("1 reset values");

    // Whole RAM gets a defined pattern so every later read has a model value
    write_burst(4'h0, word_addr(0), 8'd255, BURST_INCR, 1'b1, 1'b0);

    start_test();
    for (int t = 0; t < 8; t++) begin
      start = int'($urandom_range(255));
      write_burst(4'($urandom()), word_addr(start), 8'd0, BURST_INCR, 1'b0, 1'b0);
      read_burst(4'($urandom()), word_addr(start), 8'd0, BURST_INCR, 1'b0);
    end
    finish_test("2 single beats");

    start_test();
    for (int t = 0; t < 8; t++) begin
      len   = 8'($urandom_range(15));
      start = int'($urandom_range(255 - int'(len)));
      write_burst(4'($urandom()), word_addr(start), len, BURST_INCR, 1'b0, 1'b0);
      read_burst(4'($urandom()), word_addr(start), len, BURST_INCR, 1'b0);
    end
    finish_test("3 INCR bursts");

    start_test();
    for (int t = 0; t < 2; t++) begin
      start = int'($urandom_range(255));
      write_burst(4'($urandom()), word_addr(start), 8'($urandom_range(3, 1)),
                  BURST_FIXED, 1'b0, 1'b0);
      read_burst(4'($urandom()), word_addr(start), 8'($urandom_range(3, 1)), BURST_FIXED, 1'b0);
    end
    finish_test("4 FIXED bursts");

    // Writes go to the lower half and reads to the upper half
    start_test();
    for (int t = 0; t < 4; t++) begin
      fork
        write_burst(4'($urandom()), word_addr(int'($urandom_range(112))),
                    8'($urandom_range(15)), BURST_INCR, 1'b0, 1'b1);
        read_burst(4'($urandom()), word_addr(128 + int'($urandom_range(112))),
                   8'($urandom_range(15)), BURST_INCR, 1'b1);
      join
    end
    // Lower half read back to check the concurrent writes
    read_burst(4'($urandom()), word_addr(0), 8'd127, BURST_INCR, 1'b0);
    finish_test("5 concurrent bursts with back-pressure");

    $display("Tests run %0d, passed %0d, failed %0d, value errors %0d",
             test_pass + test_fail, test_pass, test_fail, err_cnt);
    if (test_fail == 0 && err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+include
source/axi_mem_pkg.sv
source/mem_port_pkg.sv
source/byte_lane_ram.sv
source/mem_port_arbiter.sv
source/axi_write_engine.sv
source/axi_read_engine.sv
source/axi_mem_top.sv
tb/tb_axi_mem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the AXI memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_axi_mem -o sim_tb_axi_mem

./obj_dir/sim_tb_axi_mem | tee sim.log

if grep -q "All tests passed" sim.log; then
  exit 0
else
  exit 1
fi
